/* rtl/graph_bus_config.svh */
// Graph memory bus configuration
`ifndef GRAPH_BUS_CONFIG_SVH
`define GRAPH_BUS_CONFIG_SVH

// edge processing elements sharing the bus
`define NUM_EDGE_PE 4

// node id width in bits
`define NODE_ID_W 8

// entries per memory controller queue
`define MEM_QUEUE_DEPTH 4

`endif

/* rtl/pe_req_pkg.sv */
// PE request types
`include "graph_bus_config.svh"

package pe_req_pkg;

    // what the PE asks for
    typedef enum logic {
        REQ_NEIGHBOR = 1'b0,
        REQ_FEATURE  = 1'b1
    } req_type_e;

    // node id as sent by the PE
    typedef logic [`NODE_ID_W-1:0] node_id_t;

    // index of the requesting PE, used as tag
    typedef logic [$clog2(`NUM_EDGE_PE)-1:0] pe_tag_t;

endpackage

/* rtl/mem_cntl_pkg.sv */
// Memory controller request types
`include "graph_bus_config.svh"

package mem_cntl_pkg;

    // queue entry toward a memory controller
    // node id in the upper bits, PE tag below
    typedef struct packed {
        pe_req_pkg::node_id_t node_id;
        pe_req_pkg::pe_tag_t  pe_tag;
    } mem_req_t;

endpackage

/* rtl/pe_req_slot.sv */
// PE request holding slot
`timescale 1ns/1ps
`include "graph_bus_config.svh"

module pe_req_slot (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  pe_req_pkg::req_type_e req_type,
    input  pe_req_pkg::node_id_t  node_id,
    input  logic                  take,
    output logic                  pending,
    output pe_req_pkg::req_type_e held_type,
    output pe_req_pkg::node_id_t  held_node_id
);

    logic capture;

    // a pulse while a request is held is dropped
    assign capture = req && !pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (take) begin
            pending <= 1'b0;
        end else if (capture) begin
            pending <= 1'b1;
        end
    end

    // payload only moves on capture
    always_ff @(posedge clk) begin
        if (capture) begin
            held_type    <= req_type;
            held_node_id <= node_id;
        end
    end

endmodule

/* rtl/rr_arbiter.sv */
// Round-robin arbiter
`timescale 1ns/1ps
`include "graph_bus_config.svh"

module rr_arbiter #(
    parameter int num_reqs = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [num_reqs-1:0] reqs,
    output logic [num_reqs-1:0] grants
);

    localparam int ptr_w = (num_reqs > 1) ? $clog2(num_reqs) : 1;

    logic [ptr_w-1:0] ptr;
    logic [ptr_w-1:0] grant_idx;
    logic             found;

    // search from the pointer, wrapping past the top
    always_comb begin
        int idx;
        grants    = '0;
        grant_idx = '0;
        found     = 1'b0;
        for (int k = 0; k < num_reqs; k++) begin
            idx = (int'(ptr) + k) % num_reqs;
            if (!found && reqs[idx]) begin
                grants[idx] = 1'b1;
                grant_idx   = ptr_w'(idx);
                found       = 1'b1;
            end
        end
    end

    // winner gets lowest priority next time
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (found) begin
            if (grant_idx == ptr_w'(num_reqs - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= grant_idx + 1'b1;
            end
        end
    end

endmodule

/* rtl/bus_arbiter.sv */
// Request bus arbiter and router
`timescale 1ns/1ps
`include "graph_bus_config.svh"

module bus_arbiter (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic [`NUM_EDGE_PE-1:0]                    pending,
    input  pe_req_pkg::req_type_e [`NUM_EDGE_PE-1:0]   held_type,
    input  pe_req_pkg::node_id_t [`NUM_EDGE_PE-1:0]    held_node_id,
    input  logic                                       nbr_full,
    input  logic                                       fv_full,
    output logic [`NUM_EDGE_PE-1:0]                    grant,
    output logic                                       nbr_push,
    output mem_cntl_pkg::mem_req_t                     nbr_entry,
    output logic                                       fv_push,
    output mem_cntl_pkg::mem_req_t                     fv_entry
);

    logic [`NUM_EDGE_PE-1:0] eligible;

    // a request competes only if its channel can take it
    always_comb begin
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (held_type[i] == pe_req_pkg::REQ_NEIGHBOR) begin
                eligible[i] = pending[i] && !nbr_full;
            end else begin
                eligible[i] = pending[i] && !fv_full;
            end
        end
    end

    rr_arbiter #(
        .num_reqs(`NUM_EDGE_PE)
    ) u_rr (
        .clk   (clk),
        .reset (reset),
        .reqs  (eligible),
        .grants(grant)
    );

    // route the winner by type, tag is its index
    always_comb begin
        nbr_push  = 1'b0;
        fv_push   = 1'b0;
        nbr_entry = '0;
        fv_entry  = '0;
        for (int i = 0; i < `NUM_EDGE_PE; i++) begin
            if (grant[i]) begin
                case (held_type[i])
                    pe_req_pkg::REQ_NEIGHBOR: begin
                        nbr_push          = 1'b1;
                        nbr_entry.node_id = held_node_id[i];
                        nbr_entry.pe_tag  = pe_req_pkg::pe_tag_t'(i);
                    end
                    pe_req_pkg::REQ_FEATURE: begin
                        fv_push          = 1'b1;
                        fv_entry.node_id = held_node_id[i];
                        fv_entry.pe_tag  = pe_req_pkg::pe_tag_t'(i);
                    end
                    default: begin
                        nbr_push = 1'b0;
                        fv_push  = 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

/* rtl/mem_req_fifo.sv */
// Memory controller request queue
`timescale 1ns/1ps
`include "graph_bus_config.svh"

module mem_req_fifo #(
    parameter int depth = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  mem_cntl_pkg::mem_req_t entry,
    input  logic                   ready,
    output logic                   full,
    output logic                   out_valid,
    output mem_cntl_pkg::mem_req_t out_req
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    mem_cntl_pkg::mem_req_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             pop;

    assign full      = (count == cnt_w'(depth));
    assign out_valid = (count != '0);
    assign out_req   = mem[rd_ptr];
    assign pop       = out_valid && ready;

    // storage, the arbiter never pushes when full
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rtl/graph_mem_bus.sv */
// Graph accelerator memory request bus
`timescale 1ns/1ps
`include "graph_bus_config.svh"

module graph_mem_bus (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [`NUM_EDGE_PE-1:0]                 pe_req,
    input  logic [`NUM_EDGE_PE-1:0]                 pe_req_type,
    input  pe_req_pkg::node_id_t [`NUM_EDGE_PE-1:0] pe_node_id,
    input  logic                                    nbr_ready,
    input  logic                                    fv_ready,
    output logic [`NUM_EDGE_PE-1:0]                 pe_busy,
    output logic                                    nbr_valid,
    output pe_req_pkg::node_id_t                    nbr_node_id,
    output pe_req_pkg::pe_tag_t                     nbr_pe_tag,
    output logic                                    fv_valid,
    output pe_req_pkg::node_id_t                    fv_node_id,
    output pe_req_pkg::pe_tag_t                     fv_pe_tag
);

    logic [`NUM_EDGE_PE-1:0]                     pending;
    logic [`NUM_EDGE_PE-1:0]                     grant;
    pe_req_pkg::req_type_e [`NUM_EDGE_PE-1:0]    held_type;
    pe_req_pkg::node_id_t [`NUM_EDGE_PE-1:0]     held_node_id;

    logic                   nbr_push;
    logic                   nbr_full;
    mem_cntl_pkg::mem_req_t nbr_entry;
    mem_cntl_pkg::mem_req_t nbr_out_req;
    logic                   fv_push;
    logic                   fv_full;
    mem_cntl_pkg::mem_req_t fv_entry;
    mem_cntl_pkg::mem_req_t fv_out_req;

    // one slot per PE, pending is the busy flag
    for (genvar i = 0; i < `NUM_EDGE_PE; i++) begin : g_slot
        pe_req_slot u_slot (
            .clk         (clk),
            .reset       (reset),
            .req         (pe_req[i]),
            .req_type    (pe_req_pkg::req_type_e'(pe_req_type[i])),
            .node_id     (pe_node_id[i]),
            .take        (grant[i]),
            .pending     (pending[i]),
            .held_type   (held_type[i]),
            .held_node_id(held_node_id[i])
        );
    end

    assign pe_busy = pending;

    bus_arbiter u_arb (
        .clk         (clk),
        .reset       (reset),
        .pending     (pending),
        .held_type   (held_type),
        .held_node_id(held_node_id),
        .nbr_full    (nbr_full),
        .fv_full     (fv_full),
        .grant       (grant),
        .nbr_push    (nbr_push),
        .nbr_entry   (nbr_entry),
        .fv_push     (fv_push),
        .fv_entry    (fv_entry)
    );

    // neighbor list channel
    mem_req_fifo #(
        .depth(`MEM_QUEUE_DEPTH)
    ) nbr_q (
        .clk      (clk),
        .reset    (reset),
        .push     (nbr_push),
        .entry    (nbr_entry),
        .ready    (nbr_ready),
        .full     (nbr_full),
        .out_valid(nbr_valid),
        .out_req  (nbr_out_req)
    );

    // feature vector channel
    mem_req_fifo #(
        .depth(`MEM_QUEUE_DEPTH)
    ) fv_q (
        .clk      (clk),
        .reset    (reset),
        .push     (fv_push),
        .entry    (fv_entry),
        .ready    (fv_ready),
        .full     (fv_full),
        .out_valid(fv_valid),
        .out_req  (fv_out_req)
    );

    assign nbr_node_id = nbr_out_req.node_id;
    assign nbr_pe_tag  = nbr_out_req.pe_tag;
    assign fv_node_id  = fv_out_req.node_id;
    assign fv_pe_tag   = fv_out_req.pe_tag;

endmodule

/* verif/graph_mem_bus_assert.sv */
// Request bus protocol assertions
`timescale 1ns/1ps
`include "graph_bus_config.svh"

module graph_mem_bus_assert (
    input logic                    clk,
    input logic                    reset,
    input logic [`NUM_EDGE_PE-1:0] grant,
    input logic [`NUM_EDGE_PE-1:0] pe_busy,
    input logic                    nbr_push,
    input logic                    nbr_full,
    input logic                    fv_push,
    input logic                    fv_full,
    input logic                    nbr_valid,
    input logic                    nbr_ready,
    input mem_cntl_pkg::mem_req_t  nbr_out_req,
    input logic                    fv_valid,
    input logic                    fv_ready,
    input mem_cntl_pkg::mem_req_t  fv_out_req
);

    grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
        else $error("grant has more than one bit set");

    no_push_full: assert property (@(posedge clk) disable iff (reset)
        !(nbr_push && nbr_full) && !(fv_push && fv_full))
        else $error("push into a full queue");

    // stalled output holds its entry
    nbr_hold: assert property (@(posedge clk) disable iff (reset)
        nbr_valid && !nbr_ready |=> nbr_valid && $stable(nbr_out_req))
        else $error("neighbor output changed while stalled");

    fv_hold: assert property (@(posedge clk) disable iff (reset)
        fv_valid && !fv_ready |=> fv_valid && $stable(fv_out_req))
        else $error("feature output changed while stalled");

    for (genvar i = 0; i < `NUM_EDGE_PE; i++) begin : g_busy
        busy_fall: assert property (@(posedge clk) disable iff (reset)
            $fell(pe_busy[i]) |-> $past(grant[i]))
            else $error("PE %0d busy dropped without a grant", i);
    end

endmodule

bind graph_mem_bus graph_mem_bus_assert u_bus_assert (
    .clk        (clk),
    .reset      (reset),
    .grant      (grant),
    .pe_busy    (pe_busy),
    .nbr_push   (nbr_push),
    .nbr_full   (nbr_full),
    .fv_push    (fv_push),
    .fv_full    (fv_full),
    .nbr_valid  (nbr_valid),
    .nbr_ready  (nbr_ready),
    .nbr_out_req(nbr_out_req),
    .fv_valid   (fv_valid),
    .fv_ready   (fv_ready),
    .fv_out_req (fv_out_req)
);

/* verif/graph_mem_bus_tb.sv */
// Graph memory bus testbench
`timescale 1ns/1ps
`include "graph_bus_config.svh"

module graph_mem_bus_tb;

    localparam int num_rows      = 8;
    localparam int reset_cycles  = 16;
    localparam int timeout_limit = 40 * num_rows + reset_cycles;
    // ready pattern per channel
    localparam int rdy_low  = 0;
    localparam int rdy_high = 1;
    localparam int rdy_rand = 2;

    typedef struct {
        logic [`NUM_EDGE_PE-1:0]            mask;
        logic [`NUM_EDGE_PE-1:0]            types;
        logic [`NUM_EDGE_PE*`NODE_ID_W-1:0] ids;
        int                                 pulses;
        int                                 nbr_mode;
        int                                 fv_mode;
        int                                 exp_nbr;
        int                                 exp_fv;
        logic [`NUM_EDGE_PE-1:0]            exp_busy;
        bit                                 ordered;
    } row_t;

    logic                                    clk;
    logic                                    reset;
    logic [`NUM_EDGE_PE-1:0]                 pe_req;
    logic [`NUM_EDGE_PE-1:0]                 pe_req_type;
    pe_req_pkg::node_id_t [`NUM_EDGE_PE-1:0] pe_node_id;
    logic                                    nbr_ready;
    logic                                    fv_ready;
    logic [`NUM_EDGE_PE-1:0]                 pe_busy;
    logic                                    nbr_valid;
    logic                                    fv_valid;
    pe_req_pkg::node_id_t                    nbr_node_id;
    pe_req_pkg::node_id_t                    fv_node_id;
    pe_req_pkg::pe_tag_t                     nbr_pe_tag;
    pe_req_pkg::pe_tag_t                     fv_pe_tag;

    row_t                   rows [num_rows];
    mem_cntl_pkg::mem_req_t nbr_exp [$];
    mem_cntl_pkg::mem_req_t fv_exp [$];
    int     nbr_seen   = 0;
    int     fv_seen    = 0;
    int     nbr_target = 0;
    int     fv_target  = 0;
    int     cycles     = 0;
    int     rr_ptr     = 0;
    bit     ordered    = 1'b1;
    integer seed       = 32'hec00;

    graph_mem_bus dut0 (.*);

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // walk the round-robin order from the model pointer and split by type bit
    task automatic predict_row(input row_t row);
        int idx;
        int last;
        mem_cntl_pkg::mem_req_t pair;
        last = -1;
        for (int k = 0; k < `NUM_EDGE_PE; k++) begin
            idx = (rr_ptr + k) % `NUM_EDGE_PE;
            if (row.mask[idx]) begin
                pair.node_id = row.ids[idx*`NODE_ID_W +: `NODE_ID_W];
                pair.pe_tag  = pe_req_pkg::pe_tag_t'(idx);
                if (row.types[idx]) begin
                    fv_exp.push_back(pair);
                end else begin
                    nbr_exp.push_back(pair);
                end
                last = idx;
            end
        end
        if (last >= 0) begin
            rr_ptr = (last + 1) % `NUM_EDGE_PE;
        end
    endtask

    task automatic score_output(ref mem_cntl_pkg::mem_req_t exp_q [$],
                                input mem_cntl_pkg::mem_req_t got, input string chan);
        int hit;
        hit = -1;
        if (exp_q.size() == 0) begin
            $display("%s channel delivered an entry with none outstanding", chan);
            abort_run();
        end else if (ordered) begin
            check_equal(32'(got), 32'(exp_q[0]), {chan, " entry order"});
            exp_q.delete(0);
        end else begin
            for (int k = 0; k < exp_q.size(); k++) begin
                if (hit < 0 && exp_q[k] == got) begin
                    hit = k;
                end
            end
            if (hit < 0) begin
                $display("MISMATCH at %0t: %s node %0h tag %0d was never requested",
                         $time, chan, got.node_id, got.pe_tag);
                abort_run();
            end else begin
                exp_q.delete(hit);
            end
        end
    endtask

    task automatic drive_ready(input int nbr_mode, input int fv_mode);
        if (nbr_mode == rdy_rand) begin
            nbr_ready = 1'($random(seed));
        end else begin
            nbr_ready = (nbr_mode == rdy_high);
        end
        if (fv_mode == rdy_rand) begin
            fv_ready = 1'($random(seed));
        end else begin
            fv_ready = (fv_mode == rdy_high);
        end
    endtask

    task automatic run_row(input row_t row);
        nbr_target += row.exp_nbr;
        fv_target  += row.exp_fv;
        ordered = row.ordered;
        predict_row(row);
        pe_req      = row.mask;
        pe_req_type = row.types;
        pe_node_id  = row.ids;
        drive_ready(row.nbr_mode, row.fv_mode);
        // a second pulse lands while the PEs are still busy
        repeat (row.pulses) @(negedge clk);
        pe_req = '0;
        while (nbr_seen < nbr_target || fv_seen < fv_target || pe_busy !== row.exp_busy) begin
            drive_ready(row.nbr_mode, row.fv_mode);
            @(negedge clk);
        end
    endtask

    // output handshakes
    always @(posedge clk) begin
        if (!reset && nbr_valid && nbr_ready) begin
            score_output(nbr_exp, {nbr_node_id, nbr_pe_tag}, "neighbor");
            nbr_seen++;
        end
        if (!reset && fv_valid && fv_ready) begin
            score_output(fv_exp, {fv_node_id, fv_pe_tag}, "feature");
            fv_seen++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            $display("timeout after %0d cycles waiting for a row to complete", timeout_limit);
            abort_run();
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        pe_req      = '0;
        pe_req_type = '0;
        pe_node_id  = '0;
        nbr_ready   = 1'b0;
        fv_ready    = 1'b0;
        // mask, types, ids PE3..PE0, pulses, nbr rdy, fv rdy, nbr, fv, busy, ordered
        rows[0] = '{4'b1111, 4'b1111, 32'h43424140, 1, rdy_high, rdy_high, 0, 4, 4'h0, 1'b1};
        rows[1] = '{4'b0110, 4'b0100, 32'h00525100, 1, rdy_high, rdy_high, 1, 1, 4'h0, 1'b1};
        rows[2] = '{4'b1111, 4'b0000, 32'h63626160, 1, rdy_low, rdy_high, 0, 0, 4'h0, 1'b1};
        rows[3] = '{4'b0011, 4'b0010, 32'h00007170, 1, rdy_low, rdy_high, 0, 1, 4'h1, 1'b1};
        rows[4] = '{4'b0000, 4'b0000, 32'h00000000, 1, rdy_high, rdy_high, 5, 0, 4'h0, 1'b1};
        rows[5] = '{4'b1111, 4'b0000, 32'h83828180, 2, rdy_high, rdy_high, 4, 0, 4'h0, 1'b0};
        rows[6] = '{4'b1111, 4'b1010, 32'h93929190, 1, rdy_rand, rdy_rand, 2, 2, 4'h0, 1'b0};
        rows[7] = '{4'b1111, 4'b0110, 32'ha3a2a1a0, 1, rdy_rand, rdy_rand, 2, 2, 4'h0, 1'b0};
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        check_equal(32'(pe_busy), 0, "pe_busy after reset");
        check_equal(32'(nbr_valid), 0, "nbr_valid after reset");
        check_equal(32'(fv_valid), 0, "fv_valid after reset");
        for (int r = 0; r < num_rows; r++) begin
            run_row(rows[r]);
        end
        // nothing more may show up in the idle tail
        drive_ready(rdy_high, rdy_high);
        repeat (8) @(negedge clk);
        check_equal(nbr_seen, nbr_target, "neighbor entries delivered");
        check_equal(fv_seen, fv_target, "feature entries delivered");
        check_equal(nbr_exp.size() + fv_exp.size(), 0, "entries still outstanding");
        $display("No errors");
        $finish;
    end

endmodule

/* tb.f */
+incdir+rtl
rtl/pe_req_pkg.sv
rtl/mem_cntl_pkg.sv
rtl/pe_req_slot.sv
rtl/rr_arbiter.sv
rtl/bus_arbiter.sv
rtl/mem_req_fifo.sv
rtl/graph_mem_bus.sv
verif/graph_mem_bus_assert.sv
verif/graph_mem_bus_tb.sv
